//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module pipeline_tb \
	-o pipeline_tb_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/pipeline_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/pipeline.sv
verif/axi_lite_mem.sv
verif/pipeline_tb.sv

//--- verif/axi_lite_mem.sv
`timescale 1ns/1ps

module axi_lite_mem #(
	parameter int seed_init = 33201
) (
	input	logic			clk,
	input	logic			rst_n,
	input	logic	[31:0]	araddr,
	input	logic			arvalid,
	output	logic			arready,
	output	logic	[31:0]	rdata,
	output	logic			rvalid,
	input	logic			rready,
	input	logic	[31:0]	awaddr,
	input	logic			awvalid,
	output	logic			awready,
	input	logic	[31:0]	wdata,
	input	logic			wvalid,
	output	logic			wready,
	output	logic			bvalid,
	input	logic			bready,
	// one-cycle pulse per completed write
	output	logic			wr_fire,
	output	logic	[31:0]	wr_addr,
	output	logic	[31:0]	wr_data
);

	logic	[31:0]	mem [0:1023];
	int				seed;
	logic			have_ar;
	logic			have_aw;
	logic			have_w;
	logic	[31:0]	ra;
	logic	[31:0]	wa;
	logic	[31:0]	wd;
	logic			ar_hs;
	logic			r_hs;
	logic			aw_hs;
	logic			w_hs;
	logic			b_hs;
	logic	[31:0]	s_araddr;
	logic	[31:0]	s_awaddr;
	logic	[31:0]	s_wdata;

	initial begin
		seed = seed_init;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		wr_fire = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		have_ar = 1'b0;
		have_aw = 1'b0;
		have_w = 1'b0;
		ra = '0;
		wa = '0;
		wd = '0;
	end

	always @(posedge clk) begin
		// handshakes as seen on the edge
		ar_hs = arvalid && arready;
		r_hs = rvalid && rready;
		aw_hs = awvalid && awready;
		w_hs = wvalid && wready;
		b_hs = bvalid && bready;
		s_araddr = araddr;
		s_awaddr = awaddr;
		s_wdata = wdata;
		#1;
		wr_fire = 1'b0;
		if (!rst_n) begin
			arready = 1'b0;
			rvalid = 1'b0;
			awready = 1'b0;
			wready = 1'b0;
			bvalid = 1'b0;
			have_ar = 1'b0;
			have_aw = 1'b0;
			have_w = 1'b0;
		end else begin
			if (ar_hs) begin
				have_ar = 1'b1;
				ra = s_araddr;
			end
			if (r_hs) begin
				rvalid = 1'b0;
			end
			if (have_ar && !rvalid && ($random(seed) & 3) != 0) begin
				rvalid = 1'b1;
				rdata = mem[ra[11:2]];
				have_ar = 1'b0;
			end
			arready = !have_ar && !rvalid && ($random(seed) & 1) != 0;

			if (aw_hs) begin
				have_aw = 1'b1;
				wa = s_awaddr;
			end
			if (w_hs) begin
				have_w = 1'b1;
				wd = s_wdata;
			end
			if (b_hs) begin
				bvalid = 1'b0;
			end
			if (have_aw && have_w && !bvalid && ($random(seed) & 1) != 0) begin
				mem[wa[11:2]] = wd;
				bvalid = 1'b1;
				wr_fire = 1'b1;
				wr_addr = wa;
				wr_data = wd;
				have_aw = 1'b0;
				have_w = 1'b0;
			end
			awready = !have_aw && !bvalid && ($random(seed) & 1) != 0;
			wready = !have_w && !bvalid && ($random(seed) & 1) != 0;
		end
	end

endmodule

//--- verif/pipeline_tb.sv
`timescale 1ns/1ps

module pipeline_tb import core_pkg::*;
();

	localparam logic [31:0] halt_addr = 32'h0000_03fc;

	logic			clk;
	logic			rst_n;
	logic	[31:0]	imem_araddr;
	logic	[2:0]	imem_arprot;
	logic			imem_arvalid;
	logic			imem_arready;
	logic	[31:0]	imem_rdata;
	logic			imem_rvalid;
	logic			imem_rready;
	logic	[31:0]	dmem_awaddr;
	logic	[2:0]	dmem_awprot;
	logic			dmem_awvalid;
	logic			dmem_awready;
	logic	[31:0]	dmem_wdata;
	logic	[3:0]	dmem_wstrb;
	logic			dmem_wvalid;
	logic			dmem_wready;
	logic			dmem_bvalid;
	logic			dmem_bready;
	logic	[31:0]	dmem_araddr;
	logic	[2:0]	dmem_arprot;
	logic			dmem_arvalid;
	logic			dmem_arready;
	logic	[31:0]	dmem_rdata;
	logic			dmem_rvalid;
	logic			dmem_rready;
	logic			wr_fire;
	logic	[31:0]	wr_addr;
	logic	[31:0]	wr_data;

	logic	[31:0]	prog [0:31];
	int				prog_len;
	logic	[31:0]	exp_addr [$];
	logic	[31:0]	exp_data [$];
	int				errors;
	int				checks;
	logic			halt_seen;
	logic			first_ar_seen;

	pipeline pipeline_inst (
		.clk(clk), .rst_n(rst_n),
		.imem_axi_araddr(imem_araddr), .imem_axi_arprot(imem_arprot),
		.imem_axi_arvalid(imem_arvalid), .imem_axi_arready(imem_arready),
		.imem_axi_rdata(imem_rdata), .imem_axi_rvalid(imem_rvalid),
		.imem_axi_rready(imem_rready),
		.dmem_axi_awaddr(dmem_awaddr), .dmem_axi_awprot(dmem_awprot),
		.dmem_axi_awvalid(dmem_awvalid), .dmem_axi_awready(dmem_awready),
		.dmem_axi_wdata(dmem_wdata), .dmem_axi_wstrb(dmem_wstrb),
		.dmem_axi_wvalid(dmem_wvalid), .dmem_axi_wready(dmem_wready),
		.dmem_axi_bvalid(dmem_bvalid), .dmem_axi_bready(dmem_bready),
		.dmem_axi_araddr(dmem_araddr), .dmem_axi_arprot(dmem_arprot),
		.dmem_axi_arvalid(dmem_arvalid), .dmem_axi_arready(dmem_arready),
		.dmem_axi_rdata(dmem_rdata), .dmem_axi_rvalid(dmem_rvalid),
		.dmem_axi_rready(dmem_rready)
	);

	axi_lite_mem #(.seed_init(33201)) imem_inst (
		.clk(clk), .rst_n(rst_n),
		.araddr(imem_araddr), .arvalid(imem_arvalid), .arready(imem_arready),
		.rdata(imem_rdata), .rvalid(imem_rvalid), .rready(imem_rready),
		.awaddr(32'h0), .awvalid(1'b0), .awready(),
		.wdata(32'h0), .wvalid(1'b0), .wready(),
		.bvalid(), .bready(1'b0),
		.wr_fire(), .wr_addr(), .wr_data()
	);

	axi_lite_mem #(.seed_init(33201)) dmem_inst (
		.clk(clk), .rst_n(rst_n),
		.araddr(dmem_araddr), .arvalid(dmem_arvalid), .arready(dmem_arready),
		.rdata(dmem_rdata), .rvalid(dmem_rvalid), .rready(dmem_rready),
		.awaddr(dmem_awaddr), .awvalid(dmem_awvalid), .awready(dmem_awready),
		.wdata(dmem_wdata), .wvalid(dmem_wvalid), .wready(dmem_wready),
		.bvalid(dmem_bvalid), .bready(dmem_bready),
		.wr_fire(wr_fire), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	function automatic logic [31:0] data_fill(input int i);
		return (32'(i) * 32'h0100_0193) ^ 32'hc3a5_0000;
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b010 & {3{op == op_load}}, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	task automatic build_program();
		prog[0] = {20'h12345, 5'd1, op_lui};
		prog[1] = i_type(op_imm, 5'd2, 5'd0, 12'h100);
		prog[2] = i_type(op_imm, 5'd3, 5'd1, 12'h678);
		prog[3] = s_type(5'd3, 5'd2, 12'd0);
		prog[4] = r_type(7'h00, 3'b000, 5'd4, 5'd3, 5'd1);
		prog[5] = r_type(7'h20, 3'b000, 5'd5, 5'd4, 5'd3);
		prog[6] = r_type(7'h00, 3'b111, 5'd6, 5'd5, 5'd4);
		prog[7] = r_type(7'h00, 3'b110, 5'd7, 5'd6, 5'd3);
		prog[8] = r_type(7'h00, 3'b100, 5'd8, 5'd7, 5'd1);
		prog[9] = s_type(5'd8, 5'd2, 12'd4);
		prog[10] = s_type(5'd5, 5'd2, 12'd8);
		prog[11] = i_type(op_load, 5'd9, 5'd0, 12'h040);
		prog[12] = r_type(7'h00, 3'b000, 5'd10, 5'd9, 5'd3);
		prog[13] = s_type(5'd10, 5'd2, 12'd12);
		// not taken, then taken
		prog[14] = b_type(3'b000, 5'd4, 5'd5, 13'd8);
		prog[15] = s_type(5'd6, 5'd2, 12'd16);
		prog[16] = b_type(3'b001, 5'd4, 5'd5, 13'd8);
		prog[17] = s_type(5'd0, 5'd2, 12'd20);
		prog[18] = b_type(3'b000, 5'd3, 5'd3, 13'd12);
		prog[19] = s_type(5'd0, 5'd2, 12'd24);
		prog[20] = s_type(5'd0, 5'd2, 12'd28);
		prog[21] = j_type(5'd11, 21'd12);
		prog[22] = s_type(5'd0, 5'd2, 12'd32);
		prog[23] = s_type(5'd0, 5'd2, 12'd36);
		prog[24] = s_type(5'd11, 5'd2, 12'd40);
		prog[25] = i_type(op_load, 5'd12, 5'd2, 12'd0);
		prog[26] = s_type(5'd12, 5'd2, 12'd44);
		prog[27] = s_type(5'd7, 5'd0, 12'h3fc);
		prog[28] = j_type(5'd0, 21'd0);
		prog_len = 29;
	endtask

	// instruction-level model of the same program and data image
	function automatic void ref_run();
		logic [31:0] x [32];
		logic [31:0] dm [1024];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] res;
		logic        wr;
		for (int i = 0; i < 32; i++) x[i] = '0;
		for (int i = 0; i < 1024; i++) dm[i] = data_fill(i);
		pc = reset_pc;
		for (int step = 0; step < 1000; step++) begin
			ins = prog[pc[6:2]];
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			wr = 1'b1;
			res = '0;
			addr = '0;
			case (ins[6:0])
				op_reg: case (ins[14:12])
					3'b000: res = ins[30] ? a - b : a + b;
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					default: res = a & b;
				endcase
				op_imm: res = a + {{20{ins[31]}}, ins[31:20]};
				op_lui: res = {ins[31:12], 12'b0};
				op_load: begin
					addr = a + {{20{ins[31]}}, ins[31:20]};
					res = dm[addr[11:2]];
				end
				op_store: begin
					wr = 1'b0;
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					dm[addr[11:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					if (addr == halt_addr) return;
				end
				op_branch: wr = 1'b0;
				default: res = pc + 32'd4;
			endcase
			if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
			if (ins[6:0] == op_branch && ((a == b) != ins[12])) begin
				pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			end else if (ins[6:0] == op_jal) begin
				pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end else begin
				pc = pc + 32'd4;
			end
		end
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		errors = 0;
		checks = 0;
		halt_seen = 1'b0;
		first_ar_seen = 1'b0;
		build_program();
		for (int i = 0; i < 1024; i++) begin
			imem_inst.mem[i] = (i < prog_len) ? prog[i] : (32'h0000_0013 | (32'(i) << 20));
			dmem_inst.mem[i] = data_fill(i);
		end
		ref_run();
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		wait (halt_seen);
		repeat (20) @(posedge clk);
		assert (exp_addr.size() == 0) else begin
			errors++;
			$display("missing stores: %0d expected stores never appeared", exp_addr.size());
		end
		$display("errors: %0d  checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// valids low in the last reset cycle and the first one after
	initial begin
		@(posedge clk);
		repeat (2) begin
			@(posedge clk);
			checks++;
			assert (!imem_arvalid && !dmem_arvalid && !dmem_awvalid && !dmem_wvalid) else begin
				errors++;
				$display("reset: an AXI valid was high during or right after reset");
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n && imem_arvalid && !first_ar_seen) begin
			first_ar_seen = 1'b1;
			checks++;
			assert (imem_araddr == reset_pc) else begin
				errors++;
				$display("ERROR first_fetch: expected %h, actual %h", reset_pc, imem_araddr);
			end
		end
	end

	// instruction bit of axprot and full write strobes on every valid beat
	always @(posedge clk) begin
		if (rst_n && imem_arvalid) begin
			checks++;
			assert (imem_arprot[2] == 1'b1) else begin
				errors++;
				$display("ERROR imem_arprot: expected %b, actual %b", 1'b1, imem_arprot[2]);
			end
		end
		if (rst_n && dmem_arvalid) begin
			checks++;
			assert (dmem_arprot[2] == 1'b0) else begin
				errors++;
				$display("ERROR dmem_arprot: expected %b, actual %b", 1'b0, dmem_arprot[2]);
			end
		end
		if (rst_n && dmem_awvalid) begin
			checks++;
			assert (dmem_awprot[2] == 1'b0) else begin
				errors++;
				$display("ERROR dmem_awprot: expected %b, actual %b", 1'b0, dmem_awprot[2]);
			end
		end
		if (rst_n && dmem_wvalid) begin
			checks++;
			assert (dmem_wstrb == 4'b1111) else begin
				errors++;
				$display("ERROR dmem_wstrb: expected %b, actual %b", 4'b1111, dmem_wstrb);
			end
		end
	end

	// compare each store against the reference order
	always @(posedge clk) begin
		if (rst_n && wr_fire) begin
			checks++;
			assert (exp_addr.size() != 0) else begin
				errors++;
				$display("extra store to %h with data %h after the expected list", wr_addr,
					wr_data);
			end
			if (exp_addr.size() != 0) begin
				assert (wr_addr == exp_addr[0]) else begin
					errors++;
					$display("ERROR store_addr: expected %h, actual %h", exp_addr[0], wr_addr);
				end
				assert (wr_data == exp_data[0]) else begin
					errors++;
					$display("ERROR store_data: expected %h, actual %h", exp_data[0], wr_data);
				end
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
			if (wr_addr == halt_addr) halt_seen = 1'b1;
		end
	end

	initial begin
		#1;
		repeat (prog_len * 40 + 200) @(posedge clk);
		$display("watchdog: the core did not reach the halt store in time, it hung");
		$display("errors: %0d  checks: %0d", errors + 1, checks);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_pc = '0;

	// axprot values for instruction and data accesses
	localparam logic [2:0] imem_prot = 3'b110;
	localparam logic [2:0] dmem_prot = 3'b010;

	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// one instruction word seen through three field layouts
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
	} instr_u;

	typedef struct packed {
		logic [xlen-1:0] pc;
		instr_u          instr;
	} if_id_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;
		logic [xlen-1:0] store_data;
		logic [xlen-1:0] imm;
		logic [4:0]      rd;
		logic            rd_we;
		alu_op_e         alu_op;
		logic            is_load;
		logic            is_store;
		logic            is_branch;
		logic            branch_ne;
		logic            is_jal;
	} id_ex_t;

	typedef struct packed {
		logic [xlen-1:0] result;
		logic [xlen-1:0] store_data;
		logic [4:0]      rd;
		logic            rd_we;
		logic            is_load;
		logic            is_store;
	} ex_mem_t;

	typedef struct packed {
		logic            we;
		logic [4:0]      rd;
		logic [xlen-1:0] data;
	} wb_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] target;
	} redirect_t;

endpackage

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,

	input	if_id_t		in,
	input	logic		in_valid,
	output	logic		in_ready,

	output	id_ex_t		out,
	output	logic		out_valid,
	input	logic		out_ready,

	input	id_ex_t		ex_busy,
	input	logic		ex_valid,
	input	ex_mem_t	mem_busy,
	input	logic		mem_valid,

	input	wb_t		wb,
	input	redirect_t	redirect
);

	logic	[xlen-1:0]	regs [32];
	instr_u				ir;
	logic	[4:0]		rs1;
	logic	[4:0]		rs2;
	logic	[xlen-1:0]	rs1_val;
	logic	[xlen-1:0]	rs2_val;
	logic	[xlen-1:0]	i_imm;
	logic	[xlen-1:0]	s_imm;
	logic	[xlen-1:0]	b_imm;
	logic	[xlen-1:0]	u_imm;
	logic	[xlen-1:0]	j_imm;
	logic				use_rs1;
	logic				use_rs2;
	logic				hazard;
	id_ex_t				dec;

	// rd of an older writer still in flight
	function automatic logic pending(input logic [4:0] idx);
		pending = (ex_valid && ex_busy.rd_we && ex_busy.rd == idx)
			|| (mem_valid && mem_busy.rd_we && mem_busy.rd == idx);
	endfunction

	assign ir = in.instr;
	assign rs1 = ir.r_fmt.rs1;
	assign rs2 = ir.r_fmt.rs2;

	// write-first against the writeback port
	assign rs1_val = (rs1 == 5'd0) ? '0 : (wb.we && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2_val = (rs2 == 5'd0) ? '0 : (wb.we && wb.rd == rs2) ? wb.data : regs[rs2];

	assign i_imm = {{20{ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
	assign s_imm = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
	assign b_imm = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_lo[0], ir.s_fmt.imm_hi[5:0],
		ir.s_fmt.imm_lo[4:1], 1'b0};
	assign u_imm = {ir.i_fmt.imm12, ir.i_fmt.rs1, ir.i_fmt.funct3, 12'b0};
	assign j_imm = {{12{ir.i_fmt.imm12[11]}}, ir.i_fmt.rs1, ir.i_fmt.funct3,
		ir.i_fmt.imm12[0], ir.i_fmt.imm12[10:1], 1'b0};

	always_comb begin
		dec = '0;
		dec.pc = in.pc;
		dec.rd = ir.r_fmt.rd;
		dec.op_a = rs1_val;
		dec.op_b = rs2_val;
		dec.store_data = rs2_val;
		dec.alu_op = alu_add;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (ir.r_fmt.opcode)
			op_reg: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec.rd_we = 1'b1;
				case (ir.r_fmt.funct3)
					3'b000: dec.alu_op = ir.r_fmt.funct7[5] ? alu_sub : alu_add;
					3'b100: dec.alu_op = alu_xor;
					3'b110: dec.alu_op = alu_or;
					3'b111: dec.alu_op = alu_and;
					default: dec.alu_op = alu_add;
				endcase
			end
			op_imm, op_load: begin
				use_rs1 = 1'b1;
				dec.rd_we = 1'b1;
				dec.imm = i_imm;
				dec.op_b = i_imm;
				dec.is_load = (ir.r_fmt.opcode == op_load);
			end
			op_lui: begin
				dec.rd_we = 1'b1;
				dec.imm = u_imm;
				dec.op_b = u_imm;
				dec.alu_op = alu_pass_b;
			end
			op_store: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec.imm = s_imm;
				dec.op_b = s_imm;
				dec.is_store = 1'b1;
			end
			op_branch: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec.imm = b_imm;
				dec.is_branch = 1'b1;
				dec.branch_ne = ir.r_fmt.funct3[0];
			end
			op_jal: begin
				dec.rd_we = 1'b1;
				dec.imm = j_imm;
				dec.is_jal = 1'b1;
			end
			default: ;
		endcase
		dec.rd_we = dec.rd_we && (dec.rd != 5'd0);
	end

	assign hazard = in_valid && ((use_rs1 && pending(rs1)) || (use_rs2 && pending(rs2)));
	assign in_ready = (!out_valid || out_ready) && !hazard;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (redirect.valid) begin
			out_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			out_valid <= 1'b1;
			out <= dec;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// memory only forwards rd_we set here
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb.we |-> wb.rd != 5'd0);

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,

	input	id_ex_t		in,
	input	logic		in_valid,
	output	logic		in_ready,

	output	ex_mem_t	out,
	output	logic		out_valid,
	input	logic		out_ready,

	output	redirect_t	redirect
);

	logic	[xlen-1:0]	alu_res;
	logic	[xlen-1:0]	target;
	logic	[xlen-1:0]	target_q;
	logic				taken;
	logic				taken_q;
	ex_mem_t			res;

	always_comb begin
		case (in.alu_op)
			alu_add: alu_res = in.op_a + in.op_b;
			alu_sub: alu_res = in.op_a - in.op_b;
			alu_and: alu_res = in.op_a & in.op_b;
			alu_or:  alu_res = in.op_a | in.op_b;
			alu_xor: alu_res = in.op_a ^ in.op_b;
			default: alu_res = in.op_b;
		endcase
	end

	assign taken = in.is_jal || (in.is_branch && ((in.op_a == in.op_b) != in.branch_ne));
	assign target = in.pc + in.imm;

	always_comb begin
		res.result = in.is_jal ? in.pc + 32'd4 : alu_res;
		res.store_data = in.store_data;
		res.rd = in.rd;
		res.rd_we = in.rd_we;
		res.is_load = in.is_load;
		res.is_store = in.is_store;
	end

	assign in_ready = !out_valid || out_ready;

	// fires as the taken branch moves on to memory
	assign redirect.valid = out_valid && out_ready && taken_q;
	assign redirect.target = target_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			taken_q <= 1'b0;
		end else if (redirect.valid) begin
			// wrong-path instruction behind the branch
			out_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			out_valid <= 1'b1;
			out <= res;
			taken_q <= taken;
			target_q <= target;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// only a branch or jump redirects, never a load or store
	a_redirect_branch: assert property (@(posedge clk) disable iff (!rst_n)
		redirect.valid |-> !out.is_load && !out.is_store);

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_pkg::*;
(
	input	logic				clk,
	input	logic				rst_n,

	input	redirect_t			redirect,

	output	if_id_t				out,
	output	logic				out_valid,
	input	logic				out_ready,

	output	logic	[xlen-1:0]	imem_araddr,
	output	logic				imem_arvalid,
	input	logic				imem_arready,
	input	logic	[xlen-1:0]	imem_rdata,
	input	logic				imem_rvalid,
	output	logic				imem_rready
);

	logic	[xlen-1:0]	pc;
	logic				r_wait;
	logic				stale;
	logic				busy;
	logic				issue;
	logic				r_beat;

	assign busy = imem_arvalid || r_wait;
	assign imem_rready = r_wait;
	assign r_beat = r_wait && imem_rvalid;

	// one read at a time, and only once if_id has room
	assign issue = !busy && (!out_valid || out_ready) && !redirect.valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
			imem_arvalid <= 1'b0;
			r_wait <= 1'b0;
			stale <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (redirect.valid) begin
				pc <= redirect.target;
			end else if (issue) begin
				pc <= pc + 32'd4;
			end

			if (issue) begin
				imem_arvalid <= 1'b1;
				imem_araddr <= pc;
			end else if (imem_arvalid && imem_arready) begin
				imem_arvalid <= 1'b0;
				r_wait <= 1'b1;
			end
			if (r_beat) begin
				r_wait <= 1'b0;
			end

			// read still in flight when the redirect lands gets dropped
			if (redirect.valid && busy && !r_beat) begin
				stale <= 1'b1;
			end else if (r_beat) begin
				stale <= 1'b0;
			end

			if (redirect.valid) begin
				out_valid <= 1'b0;
			end else if (r_beat && !stale) begin
				out_valid <= 1'b1;
				out.pc <= imem_araddr;
				out.instr <= imem_rdata;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		imem_arvalid && !imem_arready |=> imem_arvalid && $stable(imem_araddr));

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import core_pkg::*;
(
	input	logic				clk,
	input	logic				rst_n,

	input	ex_mem_t			in,
	input	logic				in_valid,
	output	logic				in_ready,

	output	wb_t				wb,

	output	logic	[xlen-1:0]	dmem_awaddr,
	output	logic				dmem_awvalid,
	input	logic				dmem_awready,
	output	logic	[xlen-1:0]	dmem_wdata,
	output	logic	[3:0]		dmem_wstrb,
	output	logic				dmem_wvalid,
	input	logic				dmem_wready,
	input	logic				dmem_bvalid,
	output	logic				dmem_bready,
	output	logic	[xlen-1:0]	dmem_araddr,
	output	logic				dmem_arvalid,
	input	logic				dmem_arready,
	input	logic	[xlen-1:0]	dmem_rdata,
	input	logic				dmem_rvalid,
	output	logic				dmem_rready
);

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write,
		st_wresp
	} state_e;

	state_e	state;

	// payload held by execute until this stage accepts it
	assign dmem_araddr = in.result;
	assign dmem_awaddr = in.result;
	assign dmem_wdata = in.store_data;
	assign dmem_wstrb = 4'b1111;

	assign dmem_rready = (state == st_read);
	assign dmem_bready = (state == st_wresp);

	assign in_ready = (state == st_idle && in_valid && !in.is_load && !in.is_store)
		|| (dmem_rready && dmem_rvalid)
		|| (dmem_bready && dmem_bvalid);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			dmem_arvalid <= 1'b0;
			dmem_awvalid <= 1'b0;
			dmem_wvalid <= 1'b0;
			wb.we <= 1'b0;
		end else begin
			wb.we <= in_ready && in.rd_we;
			wb.rd <= in.rd;
			wb.data <= dmem_rready ? dmem_rdata : in.result;

			case (state)
				st_idle: begin
					if (in_valid && in.is_load) begin
						dmem_arvalid <= 1'b1;
						state <= st_read;
					end else if (in_valid && in.is_store) begin
						dmem_awvalid <= 1'b1;
						dmem_wvalid <= 1'b1;
						state <= st_write;
					end
				end
				st_read: begin
					if (dmem_arready) begin
						dmem_arvalid <= 1'b0;
					end
					if (dmem_rvalid) begin
						state <= st_idle;
					end
				end
				st_write: begin
					if (dmem_awready) begin
						dmem_awvalid <= 1'b0;
					end
					if (dmem_wready) begin
						dmem_wvalid <= 1'b0;
					end
					// aw and w may finish in either order
					if ((!dmem_awvalid || dmem_awready) && (!dmem_wvalid || dmem_wready)) begin
						state <= st_wresp;
					end
				end
				default: begin
					if (dmem_bvalid) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!((dmem_arvalid || dmem_rready) && (dmem_awvalid || dmem_wvalid || dmem_bready)));

endmodule

//--- verilog/pipeline.sv
`timescale 1ns/1ps

module pipeline import core_pkg::*;
(
	input	logic				clk,
	input	logic				rst_n,

	// read-only imem port
	output	logic	[xlen-1:0]	imem_axi_araddr,
	output	logic	[2:0]		imem_axi_arprot,
	output	logic				imem_axi_arvalid,
	input	logic				imem_axi_arready,
	input	logic	[xlen-1:0]	imem_axi_rdata,
	input	logic				imem_axi_rvalid,
	output	logic				imem_axi_rready,

	// dmem port
	output	logic	[xlen-1:0]	dmem_axi_awaddr,
	output	logic	[2:0]		dmem_axi_awprot,
	output	logic				dmem_axi_awvalid,
	input	logic				dmem_axi_awready,
	output	logic	[xlen-1:0]	dmem_axi_wdata,
	output	logic	[3:0]		dmem_axi_wstrb,
	output	logic				dmem_axi_wvalid,
	input	logic				dmem_axi_wready,
	input	logic				dmem_axi_bvalid,
	output	logic				dmem_axi_bready,
	output	logic	[xlen-1:0]	dmem_axi_araddr,
	output	logic	[2:0]		dmem_axi_arprot,
	output	logic				dmem_axi_arvalid,
	input	logic				dmem_axi_arready,
	input	logic	[xlen-1:0]	dmem_axi_rdata,
	input	logic				dmem_axi_rvalid,
	output	logic				dmem_axi_rready
);

	if_id_t		if_id;
	logic		if_id_valid;
	logic		if_id_ready;
	id_ex_t		id_ex;
	logic		id_ex_valid;
	logic		id_ex_ready;
	ex_mem_t	ex_mem;
	logic		ex_mem_valid;
	logic		ex_mem_ready;
	wb_t		wb;
	redirect_t	redirect;

	assign imem_axi_arprot = imem_prot;
	assign dmem_axi_arprot = dmem_prot;
	assign dmem_axi_awprot = dmem_prot;

	fetch_stage fetch_stage_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.redirect(redirect),
		.out(if_id),
		.out_valid(if_id_valid),
		.out_ready(if_id_ready),
		.imem_araddr(imem_axi_araddr),
		.imem_arvalid(imem_axi_arvalid),
		.imem_arready(imem_axi_arready),
		.imem_rdata(imem_axi_rdata),
		.imem_rvalid(imem_axi_rvalid),
		.imem_rready(imem_axi_rready)
	);

	// scoreboard sees the id_ex and ex_mem registers
	decode_stage decode_stage_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in(if_id),
		.in_valid(if_id_valid),
		.in_ready(if_id_ready),
		.out(id_ex),
		.out_valid(id_ex_valid),
		.out_ready(id_ex_ready),
		.ex_busy(id_ex),
		.ex_valid(id_ex_valid),
		.mem_busy(ex_mem),
		.mem_valid(ex_mem_valid),
		.wb(wb),
		.redirect(redirect)
	);

	execute_stage execute_stage_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in(id_ex),
		.in_valid(id_ex_valid),
		.in_ready(id_ex_ready),
		.out(ex_mem),
		.out_valid(ex_mem_valid),
		.out_ready(ex_mem_ready),
		.redirect(redirect)
	);

	memory_stage memory_stage_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.in(ex_mem),
		.in_valid(ex_mem_valid),
		.in_ready(ex_mem_ready),
		.wb(wb),
		.dmem_awaddr(dmem_axi_awaddr),
		.dmem_awvalid(dmem_axi_awvalid),
		.dmem_awready(dmem_axi_awready),
		.dmem_wdata(dmem_axi_wdata),
		.dmem_wstrb(dmem_axi_wstrb),
		.dmem_wvalid(dmem_axi_wvalid),
		.dmem_wready(dmem_axi_wready),
		.dmem_bvalid(dmem_axi_bvalid),
		.dmem_bready(dmem_axi_bready),
		.dmem_araddr(dmem_axi_araddr),
		.dmem_arvalid(dmem_axi_arvalid),
		.dmem_arready(dmem_axi_arready),
		.dmem_rdata(dmem_axi_rdata),
		.dmem_rvalid(dmem_axi_rvalid),
		.dmem_rready(dmem_axi_rready)
	);

endmodule
